// ==== common/adc_rx_pkg.sv ====
`default_nettype none

package adc_rx_pkg;

  // word addresses, wb_adr_i[6:2]
  typedef enum logic [4:0] {
    DLY_LOAD_LO = 5'd0,   // lane bits
    DLY_LOAD_HI = 5'd1,   // frame clock bits + lclk
    DLY_RST_LO  = 5'd2,
    DLY_RST_HI  = 5'd3,
    DLY_VTC_LO  = 5'd4,
    DLY_VTC_HI  = 5'd5,
    DLY_VAL     = 5'd6,
    FCLK_ERR    = 5'd7,   // read only
    ISERDES_RST = 5'd8,
    MMCM_CTRL   = 5'd9,
    LCLK_CNT    = 5'd10,  // read only
    FCLK0_CNT   = 5'd11,
    FCLK1_CNT   = 5'd12,
    FCLK2_CNT   = 5'd13,
    FCLK3_CNT   = 5'd14,
    BITSLIP     = 5'd15,
    SNAP_TRIG   = 5'd16
  } reg_addr_e;

  localparam logic [7:0] FRAME_PATTERN = 8'hF0; // expected fclk word
  localparam int LANE_W = 8;                    // bits per lane word
  localparam int DLY_W  = 9;                    // idelay tap value

  // one delay control bit per lane, per frame clock, plus the line clock
  function automatic int dly_bits(input int num_units, input int num_fclks);
    return 8 * num_units + num_fclks + 1;
  endfunction

endpackage

`default_nettype wire

// ==== common/adc_lane_ctrl_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface adc_lane_ctrl_if #(
  parameter int NUM_UNITS = 2,
  parameter int NUM_FCLKS = 1
) ();

  localparam int CW = adc_rx_pkg::dly_bits(NUM_UNITS, NUM_FCLKS);

  logic [CW-1:0]                delay_load;    // tap load, edge sensitive downstream
  logic [CW-1:0]                delay_rst;     // holds tap at zero
  logic [CW-1:0]                delay_en_vtc;  // blocks loads while set
  logic [adc_rx_pkg::DLY_W-1:0] delay_val;
  logic [4*NUM_UNITS-1:0]       bitslip;       // one per channel
  logic                         iserdes_rst;
  logic                         snapshot_trigger;

  // register side
  modport regs (
    output delay_load, delay_rst, delay_en_vtc, delay_val,
    output bitslip, iserdes_rst, snapshot_trigger
  );

  // aligner side
  modport lanes (
    input delay_load, delay_rst, delay_en_vtc, delay_val,
    input bitslip, iserdes_rst, snapshot_trigger
  );

endinterface

`default_nettype wire

// ==== wb_ads5296_attach/wb_ads5296_attach.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_ads5296_attach #(
  parameter int NUM_UNITS = 2,
  parameter int NUM_FCLKS = 1,
  parameter int IS_MASTER = 0
) (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic [31:0]       wb_adr_i,
  input  logic [31:0]       wb_dat_i,
  input  logic [3:0]        wb_sel_i,
  input  logic              wb_we_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  output logic [31:0]       wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  input  logic              mmcm_locked_i,
  output logic              mmcm_rst_o,
  output logic              mmcm_clksel_o,
  input  logic [31:0]       fclk_err_cnt_i,
  input  logic [31:0]       lclk_cnt_i,
  input  logic [4*32-1:0]   fclk_cnt_i,    // 4 words, unused ones zero
  adc_lane_ctrl_if.regs     ctrl
);

  localparam int LW = 8 * NUM_UNITS;  // lane bits in the LO words
  localparam int CW = adc_rx_pkg::dly_bits(NUM_UNITS, NUM_FCLKS);
  localparam int HW = CW - LW;        // fclk bits + lclk in the HI words
  localparam int BW = 4 * NUM_UNITS;

  adc_rx_pkg::reg_addr_e addr;
  logic        req;
  logic        ack_r;
  logic [31:0] rd_word;    // current value at addr
  logic [31:0] rd_data_r;
  logic [31:0] wr_mask;
  logic [31:0] wr_word;    // byte-merged write data

  logic [CW-1:0]                dly_load_r;
  logic [CW-1:0]                dly_rst_r;
  logic [CW-1:0]                dly_vtc_r;
  logic [adc_rx_pkg::DLY_W-1:0] dly_val_r;
  logic [BW-1:0]                bitslip_r;
  logic iserdes_rst_r;
  logic mmcm_rst_r;
  logic mmcm_clksel_r;
  logic snap_trig_r;

  assign addr = adc_rx_pkg::reg_addr_e'(wb_adr_i[6:2]);
  assign req  = wb_stb_i && wb_cyc_i && !ack_r;  // no wait states

  // byte lanes not selected keep their old contents
  assign wr_mask = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};
  assign wr_word = (wb_dat_i & wr_mask) | (rd_word & ~wr_mask);

  // readback mux
  always_comb begin
    rd_word = 32'd0;  // undefined addresses
    case (addr)
      adc_rx_pkg::DLY_LOAD_LO: rd_word = 32'(dly_load_r[LW-1:0]);
      adc_rx_pkg::DLY_LOAD_HI: rd_word = 32'(dly_load_r[CW-1:LW]);
      adc_rx_pkg::DLY_RST_LO:  rd_word = 32'(dly_rst_r[LW-1:0]);
      adc_rx_pkg::DLY_RST_HI:  rd_word = 32'(dly_rst_r[CW-1:LW]);
      adc_rx_pkg::DLY_VTC_LO:  rd_word = 32'(dly_vtc_r[LW-1:0]);
      adc_rx_pkg::DLY_VTC_HI:  rd_word = 32'(dly_vtc_r[CW-1:LW]);
      adc_rx_pkg::DLY_VAL:     rd_word = 32'(dly_val_r);
      adc_rx_pkg::FCLK_ERR:    rd_word = fclk_err_cnt_i;
      adc_rx_pkg::ISERDES_RST: rd_word = {31'd0, iserdes_rst_r};
      adc_rx_pkg::MMCM_CTRL: begin
        // master 24, lock 16, clksel 8, rst 0
        rd_word = {7'd0, 1'(IS_MASTER), 7'd0, mmcm_locked_i,
                   7'd0, mmcm_clksel_r, 7'd0, mmcm_rst_r};
      end
      adc_rx_pkg::LCLK_CNT:    rd_word = lclk_cnt_i;
      adc_rx_pkg::FCLK0_CNT:   rd_word = fclk_cnt_i[31:0];
      adc_rx_pkg::FCLK1_CNT:   rd_word = (NUM_FCLKS > 1) ? fclk_cnt_i[63:32] : 32'd0;
      adc_rx_pkg::FCLK2_CNT:   rd_word = (NUM_FCLKS > 2) ? fclk_cnt_i[95:64] : 32'd0;
      adc_rx_pkg::FCLK3_CNT:   rd_word = (NUM_FCLKS > 3) ? fclk_cnt_i[127:96] : 32'd0;
      adc_rx_pkg::BITSLIP:     rd_word = 32'(bitslip_r);
      adc_rx_pkg::SNAP_TRIG:   rd_word = {31'd0, snap_trig_r};
      default:                 rd_word = 32'd0;
    endcase
  end

  // control registers, written at the ack edge
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_r         <= 1'b0;
      dly_load_r    <= '0;
      dly_rst_r     <= '0;
      dly_vtc_r     <= '0;
      dly_val_r     <= '0;
      bitslip_r     <= '0;
      iserdes_rst_r <= 1'b0;
      mmcm_rst_r    <= 1'b0;
      mmcm_clksel_r <= 1'b0;
      snap_trig_r   <= 1'b0;
    end else begin
      ack_r <= req;  // single cycle, req drops once ack is up
      if (req && wb_we_i) begin
        case (addr)
          adc_rx_pkg::DLY_LOAD_LO: dly_load_r[LW-1:0] <= wr_word[LW-1:0];
          adc_rx_pkg::DLY_LOAD_HI: dly_load_r[CW-1:LW] <= wr_word[HW-1:0];
          adc_rx_pkg::DLY_RST_LO:  dly_rst_r[LW-1:0] <= wr_word[LW-1:0];
          adc_rx_pkg::DLY_RST_HI:  dly_rst_r[CW-1:LW] <= wr_word[HW-1:0];
          adc_rx_pkg::DLY_VTC_LO:  dly_vtc_r[LW-1:0] <= wr_word[LW-1:0];
          adc_rx_pkg::DLY_VTC_HI:  dly_vtc_r[CW-1:LW] <= wr_word[HW-1:0];
          adc_rx_pkg::DLY_VAL:     dly_val_r <= wr_word[adc_rx_pkg::DLY_W-1:0];
          adc_rx_pkg::ISERDES_RST: iserdes_rst_r <= wr_word[0];
          adc_rx_pkg::MMCM_CTRL: begin
            mmcm_rst_r    <= wr_word[0];
            mmcm_clksel_r <= wr_word[8];
          end
          adc_rx_pkg::BITSLIP:     bitslip_r <= wr_word[BW-1:0];
          adc_rx_pkg::SNAP_TRIG:   snap_trig_r <= wr_word[0];
          default: begin
          end  // status words ignore writes
        endcase
      end
    end
  end

  // read data sampled with the request
  always_ff @(posedge wb_clk_i) begin
    if (req && !wb_we_i)
      rd_data_r <= rd_word;
  end

  assign wb_ack_o = ack_r;
  assign wb_dat_o = ack_r ? rd_data_r : 32'd0;  // only valid during ack
  assign wb_err_o = 1'b0;

  assign mmcm_rst_o    = mmcm_rst_r;
  assign mmcm_clksel_o = mmcm_clksel_r;

  assign ctrl.delay_load       = dly_load_r;
  assign ctrl.delay_rst        = dly_rst_r;
  assign ctrl.delay_en_vtc     = dly_vtc_r;
  assign ctrl.delay_val        = dly_val_r;
  assign ctrl.bitslip          = bitslip_r;
  assign ctrl.iserdes_rst      = iserdes_rst_r;
  assign ctrl.snapshot_trigger = snap_trig_r;

endmodule

`default_nettype wire

// ==== design/adc_frame_aligner.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_frame_aligner #(
  parameter int NUM_UNITS = 2,
  parameter int NUM_FCLKS = 1
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic [8*NUM_UNITS*adc_rx_pkg::LANE_W-1:0] lane_data_i,
  input  logic [7:0]                                fclk_data_i,
  input  logic                                      lane_valid_i,
  adc_lane_ctrl_if.lanes                            ctrl,
  output logic [8*NUM_UNITS*adc_rx_pkg::LANE_W-1:0] aligned_data_o,
  output logic [(8*NUM_UNITS+NUM_FCLKS+1)*adc_rx_pkg::DLY_W-1:0] delay_tap_o,
  output logic [31:0]                               fclk_err_cnt_o,
  output logic [8*NUM_UNITS*adc_rx_pkg::LANE_W-1:0] snap_data_o,
  output logic                                      snap_valid_o
);

  localparam int LW = adc_rx_pkg::LANE_W;
  localparam int TW = adc_rx_pkg::DLY_W;
  localparam int NL = 8 * NUM_UNITS;  // data lanes, two per channel
  localparam int BW = 4 * NUM_UNITS;  // channels
  localparam int CW = adc_rx_pkg::dly_bits(NUM_UNITS, NUM_FCLKS);

  logic [CW-1:0]    load_q;
  logic [CW-1:0]    load_rise;
  logic [CW*TW-1:0] tap_r;
  logic [BW-1:0]    bs_q;
  logic [BW-1:0]    bs_rise;
  logic [BW*3-1:0]  rot_r;      // 3 bit rotation per channel
  logic [NL*LW-1:0] rot_data;
  logic [31:0]      err_cnt;
  logic             trig_q;
  logic             trig_rise;

  // rotate left, via doubled word
  function automatic logic [LW-1:0] rotl(input logic [LW-1:0] w, input logic [2:0] r);
    logic [2*LW-1:0] dbl;
    dbl = {w, w} << r;
    return dbl[2*LW-1:LW];
  endfunction

  assign load_rise = ctrl.delay_load & ~load_q;
  assign bs_rise   = ctrl.bitslip & ~bs_q;
  assign trig_rise = ctrl.snapshot_trigger & ~trig_q;

  // delay taps
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      load_q <= '0;
      tap_r  <= '0;
    end else begin
      load_q <= ctrl.delay_load;
      for (int i = 0; i < CW; i++) begin
        if (ctrl.delay_rst[i])
          tap_r[i*TW +: TW] <= '0;  // rst wins over load
        else if (load_rise[i] && !ctrl.delay_en_vtc[i])
          tap_r[i*TW +: TW] <= ctrl.delay_val;  // vtc high blocks load
      end
    end
  end

  // bitslip rotation and frame error count
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      bs_q    <= '0;
      rot_r   <= '0;
      err_cnt <= '0;
    end else begin
      bs_q <= ctrl.bitslip;
      if (ctrl.iserdes_rst) begin
        rot_r   <= '0;
        err_cnt <= '0;
      end else begin
        for (int c = 0; c < BW; c++) begin
          if (bs_rise[c])
            rot_r[c*3 +: 3] <= rot_r[c*3 +: 3] + 3'd1;  // wraps mod 8
        end
        if (lane_valid_i && (fclk_data_i != adc_rx_pkg::FRAME_PATTERN))
          err_cnt <= err_cnt + 32'd1;
      end
    end
  end

  // both lanes of a channel share its rotation
  always_comb begin
    for (int l = 0; l < NL; l++)
      rot_data[l*LW +: LW] = rotl(lane_data_i[l*LW +: LW], rot_r[(l/2)*3 +: 3]);
  end

  // aligned output register
  always_ff @(posedge wb_clk_i) begin
    if (lane_valid_i)
      aligned_data_o <= rot_data;
  end

  // snapshot
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      trig_q       <= 1'b0;
      snap_valid_o <= 1'b0;
    end else begin
      trig_q       <= ctrl.snapshot_trigger;
      snap_valid_o <= trig_rise;  // one cycle pulse
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (trig_rise)
      snap_data_o <= aligned_data_o;
  end

  assign delay_tap_o    = tap_r;
  assign fclk_err_cnt_o = err_cnt;

endmodule

`default_nettype wire

// ==== design/adc_clk_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_clk_monitor #(
  parameter int NUM_FCLKS   = 1,
  parameter int GATE_CYCLES = 256
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 lclk_smp_i,
  input  logic [NUM_FCLKS-1:0] fclk_smp_i,
  output logic [31:0]          lclk_cnt_o,
  output logic [4*32-1:0]      fclk_cnt_o
);

  localparam int NC = NUM_FCLKS + 1;          // slot 0 is lclk
  localparam int GW = $clog2(GATE_CYCLES);

  logic [NC-1:0] smp_s1;
  logic [NC-1:0] smp_s2;
  logic [NC-1:0] smp_s3;   // previous synced value
  logic [NC-1:0] rise;
  logic [GW-1:0] gate_cnt;
  logic          gate_end;
  logic [31:0]   run_cnt [NC];
  logic [31:0]   lat_cnt [NC];

  assign rise     = smp_s2 & ~smp_s3;
  assign gate_end = (gate_cnt == GW'(GATE_CYCLES - 1));

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      smp_s1   <= '0;
      smp_s2   <= '0;
      smp_s3   <= '0;
      gate_cnt <= '0;
      for (int i = 0; i < NC; i++) begin
        run_cnt[i] <= '0;
        lat_cnt[i] <= '0;
      end
    end else begin
      smp_s1   <= {fclk_smp_i, lclk_smp_i};  // two flop sync
      smp_s2   <= smp_s1;
      smp_s3   <= smp_s2;
      gate_cnt <= gate_end ? '0 : gate_cnt + 1'b1;
      for (int i = 0; i < NC; i++) begin
        if (gate_end) begin
          lat_cnt[i] <= run_cnt[i] + 32'(rise[i]);  // last cycle counts too
          run_cnt[i] <= '0;
        end else begin
          run_cnt[i] <= run_cnt[i] + 32'(rise[i]);
        end
      end
    end
  end

  assign lclk_cnt_o = lat_cnt[0];

  // fixed 4 word output, missing frame clocks stay zero
  for (genvar k = 0; k < 4; k++) begin : g_fclk_out
    if (k < NUM_FCLKS) begin : g_used
      assign fclk_cnt_o[k*32 +: 32] = lat_cnt[k+1];
    end else begin : g_unused
      assign fclk_cnt_o[k*32 +: 32] = 32'd0;
    end
  end

endmodule

`default_nettype wire

// ==== design/adc_rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_rx_top #(
  parameter int NUM_UNITS   = 2,    // 1 to 4, 4 channels of 2 lanes each
  parameter int NUM_FCLKS   = 1,    // 1 to 4
  parameter int IS_MASTER   = 0,
  parameter int GATE_CYCLES = 256
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  input  logic        mmcm_locked_i,
  output logic        mmcm_rst_o,
  output logic        mmcm_clksel_o,
  input  logic [8*NUM_UNITS*adc_rx_pkg::LANE_W-1:0] lane_data_i,
  input  logic [7:0]                                fclk_data_i,
  input  logic                                      lane_valid_i,
  input  logic                                      lclk_smp_i,
  input  logic [NUM_FCLKS-1:0]                      fclk_smp_i,
  output logic [8*NUM_UNITS*adc_rx_pkg::LANE_W-1:0] aligned_data_o,
  output logic [(8*NUM_UNITS+NUM_FCLKS+1)*adc_rx_pkg::DLY_W-1:0] delay_tap_o,
  output logic [8*NUM_UNITS*adc_rx_pkg::LANE_W-1:0] snap_data_o,
  output logic                                      snap_valid_o
);

  logic [31:0]     fclk_err_cnt;
  logic [31:0]     lclk_cnt;
  logic [4*32-1:0] fclk_cnt;

  // register block to aligner
  adc_lane_ctrl_if #(.NUM_UNITS(NUM_UNITS), .NUM_FCLKS(NUM_FCLKS)) u_ctrl_if ();

  wb_ads5296_attach #(
    .NUM_UNITS(NUM_UNITS), .NUM_FCLKS(NUM_FCLKS), .IS_MASTER(IS_MASTER)
  ) u_attach (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_we_i(wb_we_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
    .mmcm_locked_i(mmcm_locked_i), .mmcm_rst_o(mmcm_rst_o), .mmcm_clksel_o(mmcm_clksel_o),
    .fclk_err_cnt_i(fclk_err_cnt), .lclk_cnt_i(lclk_cnt), .fclk_cnt_i(fclk_cnt),
    .ctrl(u_ctrl_if.regs)
  );

  adc_frame_aligner #(.NUM_UNITS(NUM_UNITS), .NUM_FCLKS(NUM_FCLKS)) u_aligner (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .lane_data_i(lane_data_i), .fclk_data_i(fclk_data_i), .lane_valid_i(lane_valid_i),
    .ctrl(u_ctrl_if.lanes),
    .aligned_data_o(aligned_data_o), .delay_tap_o(delay_tap_o),
    .fclk_err_cnt_o(fclk_err_cnt),
    .snap_data_o(snap_data_o), .snap_valid_o(snap_valid_o)
  );

  adc_clk_monitor #(.NUM_FCLKS(NUM_FCLKS), .GATE_CYCLES(GATE_CYCLES)) u_clk_mon (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .lclk_smp_i(lclk_smp_i), .fclk_smp_i(fclk_smp_i),
    .lclk_cnt_o(lclk_cnt), .fclk_cnt_o(fclk_cnt)
  );

endmodule

`default_nettype wire

// ==== test/tb_adc_rx_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_adc_rx_assert (
  input logic wb_clk_i,
  input logic wb_rst_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic snap_valid_i
);

  default disable iff (wb_rst_i);

  // request answered on the very next edge
  a_ack_next: assert property (@(posedge wb_clk_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_i) |=> wb_ack_i)
    else $error("wishbone request not acknowledged one cycle later");

  a_ack_single: assert property (@(posedge wb_clk_i) wb_ack_i |=> !wb_ack_i)
    else $error("wb_ack_o high for two cycles in a row");

  a_snap_pulse: assert property (@(posedge wb_clk_i) snap_valid_i |=> !snap_valid_i)
    else $error("snap_valid_o longer than one cycle");

endmodule

// wishbone handshake and snapshot pulse
bind adc_rx_top tb_adc_rx_assert u_assert (
  .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
  .wb_ack_i(wb_ack_o), .snap_valid_i(snap_valid_o)
);

`default_nettype wire

// ==== test/tb_adc_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_adc_rx;

  localparam int NUM_UNITS    = 2;
  localparam int NUM_FCLKS    = 1;
  localparam int IS_MASTER    = 1;
  localparam int GATE_CYCLES  = 256;
  localparam int RESET_CYCLES = 5;
  localparam int NCH = 4 * NUM_UNITS;                    // channels
  localparam int DW  = 8 * NUM_UNITS * adc_rx_pkg::LANE_W;
  localparam int TW  = adc_rx_pkg::DLY_W;
  localparam int CW  = adc_rx_pkg::dly_bits(NUM_UNITS, NUM_FCLKS);

  logic wb_clk_i = 1'b0;
  logic wb_rst_i;
  logic [31:0] wb_adr_i, wb_dat_i, wb_dat_o;
  logic [3:0] wb_sel_i;
  logic wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o, wb_err_o;
  logic mmcm_locked_i, mmcm_rst_o, mmcm_clksel_o;
  logic [DW-1:0] lane_data_i, aligned_data_o, snap_data_o;
  logic [7:0] fclk_data_i;
  logic lane_valid_i, lclk_smp_i, snap_valid_o;
  logic [NUM_FCLKS-1:0] fclk_smp_i;
  logic [CW*TW-1:0] delay_tap_o;

  string script[$];                 // golden lines, comments dropped
  bit script_loaded = 1'b0;
  int seed = 84460;
  int errors = 0;
  int checks = 0;
  int snap_pulses = 0;
  logic [3:0] tog_cnt;
  logic [2:0] rot_model [NCH];      // expected bitslip rotation per channel
  logic [NCH-1:0] bs_prev;          // last written BITSLIP value
  bit iser_lvl;
  bit exp_mmcm_rst;                 // last written MMCM_CTRL bits
  bit exp_mmcm_clksel;
  logic [DW-1:0] exp_aligned;

  adc_rx_top #(
    .NUM_UNITS(NUM_UNITS), .NUM_FCLKS(NUM_FCLKS), .IS_MASTER(IS_MASTER),
    .GATE_CYCLES(GATE_CYCLES)
  ) u_adc_rx_top (.*);

  always #10 wb_clk_i = ~wb_clk_i;

  // sampled clocks, lclk toggles every 2 cycles, fclk every 8
  always @(posedge wb_clk_i) begin
    #2;
    tog_cnt = tog_cnt + 4'd1;
    lclk_smp_i = tog_cnt[1];
    fclk_smp_i = {NUM_FCLKS{tog_cnt[3]}};
  end

  task automatic check_value(input string name, input logic [DW-1:0] got, exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("at %0t ns: %s", $time, msg);
  endtask

  function automatic logic [7:0] rotate_left(input logic [7:0] w, input logic [2:0] k);
    logic [7:0] r;
    for (int b = 0; b < 8; b++)
      r[(b + k) % 8] = w[b];  // bit b moves up by k
    return r;
  endfunction

  // one classic cycle, inputs moved 2 ns after the edge
  task automatic bus_cycle(input bit we, input logic [31:0] adr, dat, output logic [31:0] rdata);
    @(posedge wb_clk_i);
    #2;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    do begin
      @(posedge wb_clk_i);
      #1;
    end while (!wb_ack_o);
    rdata = wb_dat_o;  // valid only with ack
    check_value("wb_err_o", wb_err_o, 1'b0);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // bitslip edges and iserdes reset as seen by the aligner
  task automatic track_write(input logic [31:0] adr, dat);
    case (adc_rx_pkg::reg_addr_e'(adr[6:2]))
      adc_rx_pkg::BITSLIP: begin
        for (int c = 0; c < NCH; c++)
          if (dat[c] && !bs_prev[c] && !iser_lvl)
            rot_model[c] = rot_model[c] + 3'd1;
        bs_prev = dat[NCH-1:0];
      end
      adc_rx_pkg::ISERDES_RST: begin
        iser_lvl = dat[0];
        if (dat[0])
          foreach (rot_model[c]) rot_model[c] = 3'd0;
      end
      adc_rx_pkg::MMCM_CTRL: begin
        exp_mmcm_rst    = dat[0];   // rst in bit 0
        exp_mmcm_clksel = dat[8];   // clksel in bit 8
      end
      default: ;
    endcase
  endtask

  // n valid cycles of random lane words, each checked one cycle later
  task automatic drive_lanes(input int n, input bit bad_frame);
    logic [DW-1:0] pending;
    logic [7:0] fw;
    for (int i = 0; i <= n; i++) begin
      @(posedge wb_clk_i);
      #2;
      if (i > 0) begin
        exp_aligned = pending;
        check_value("aligned_data_o", aligned_data_o, exp_aligned);
      end
      if (i < n) begin
        for (int q = 0; q < DW / 32; q++)
          lane_data_i[q*32 +: 32] = $random(seed);
        fw = bad_frame ? 8'($random(seed)) : adc_rx_pkg::FRAME_PATTERN;
        if (bad_frame && fw == adc_rx_pkg::FRAME_PATTERN)
          fw = ~fw;  // force a mismatch
        fclk_data_i  = fw;
        lane_valid_i = 1'b1;
        for (int l = 0; l < DW / 8; l++)
          pending[l*8 +: 8] = rotate_left(lane_data_i[l*8 +: 8], rot_model[l/2]);
      end else begin
        lane_valid_i = 1'b0;
        fclk_data_i  = adc_rx_pkg::FRAME_PATTERN;
      end
    end
  endtask

  task automatic lane_step(input string step, input logic [31:0] a, b);
    repeat (2) @(posedge wb_clk_i);  // control registers reach the aligner
    #2;
    check_value("mmcm_rst_o", mmcm_rst_o, exp_mmcm_rst);
    check_value("mmcm_clksel_o", mmcm_clksel_o, exp_mmcm_clksel);
    case (step)
      "T": check_value("delay_tap_o", delay_tap_o[a*TW +: TW], b);
      "B": begin
        check_value("bitslip count", rot_model[a], b);
        drive_lanes(4, 1'b0);
      end
      "E": drive_lanes(a, 1'b1);
      "S": check_value("snap_valid_o pulses", snap_pulses, a);
      "K": mmcm_locked_i = a[0];
      "C": repeat (2 * GATE_CYCLES + 8) @(posedge wb_clk_i);
      default: report_failure($sformatf("unknown lane step %s in golden file", step));
    endcase
  endtask

  // snapshot scoreboard
  always @(posedge wb_clk_i) begin
    #1;
    if (snap_valid_o === 1'b1) begin
      snap_pulses++;
      check_value("snap_data_o", snap_data_o, exp_aligned);
    end
  end

  initial begin : watchdog
    int limit;
    wait (script_loaded);
    limit = script.size() * 10 + 4 * GATE_CYCLES + RESET_CYCLES;
    repeat (limit) @(posedge wb_clk_i);
    $display("timeout, script not done after %0d cycles", limit);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    int fd;
    string line, cmd, step;
    logic [31:0] a, b, rdata;
    wb_rst_i = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = 4'hF;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    mmcm_locked_i = 1'b0;
    lane_data_i  = '0;
    fclk_data_i  = adc_rx_pkg::FRAME_PATTERN;
    lane_valid_i = 1'b0;
    lclk_smp_i = 1'b0;
    fclk_smp_i = '0;
    tog_cnt = '0;
    bs_prev = '0;
    iser_lvl = 1'b0;
    exp_mmcm_rst    = 1'b0;
    exp_mmcm_clksel = 1'b0;
    foreach (rot_model[c]) rot_model[c] = 3'd0;
    fd = $fopen("test/adc_rx_golden.txt", "r");
    if (fd == 0)
      report_failure("could not open test/adc_rx_golden.txt");
    else begin
      while ($fgets(line, fd)) begin
        if ($sscanf(line, "%s", cmd) == 1 && cmd.getc(0) != "#")
          script.push_back(line);
      end
      $fclose(fd);
    end
    script_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge wb_clk_i);
    #2;
    wb_rst_i = 1'b0;
    foreach (script[i]) begin
      void'($sscanf(script[i], "%s", cmd));
      case (cmd)
        "W": begin
          void'($sscanf(script[i], "%s %h %h", cmd, a, b));
          bus_cycle(1'b1, a, b, rdata);
          track_write(a, b);
        end
        "R": begin
          void'($sscanf(script[i], "%s %h %h", cmd, a, b));
          bus_cycle(1'b0, a, 32'd0, rdata);
          check_value($sformatf("wb_dat_o[%0h]", a), rdata, b);
        end
        "L": begin
          void'($sscanf(script[i], "%s %s %h %h", cmd, step, a, b));
          lane_step(step, a, b);
        end
        default: report_failure($sformatf("bad golden line: %s", script[i]));
      endcase
    end
    repeat (4) @(posedge wb_clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/adc_rx_pkg.sv
common/adc_lane_ctrl_if.sv
wb_ads5296_attach/wb_ads5296_attach.sv
design/adc_frame_aligner.sv
design/adc_clk_monitor.sv
design/adc_rx_top.sv
test/tb_adc_rx_assert.sv
test/tb_adc_rx.sv

// ==== test/adc_rx_golden.txt ====
# columns: W byte_addr data | R byte_addr expected | L step arg1 arg2, all hex
# steps: T lane tap, B channel slips, E bad_words, S pulses, K lock, C two gates
R 00 0
R 04 0
R 18 0
R 1c 0
R 24 1000000
R 28 0
R 3c 0
R 44 0
W 18 ffffffff
R 18 1ff
W 14 ffffffff
R 14 3
W 14 0
W 18 a5
W 00 10
L T 4 a5
W 10 10
W 18 33
W 00 0
W 00 10
L T 4 a5
W 08 10
L T 4 0
W 08 0
L K 1 0
W 24 101
R 24 1010101
W 3c 4
W 3c 0
W 3c 4
R 3c 4
L B 2 2
W 20 1
W 20 0
L B 2 0
R 1c 0
L E 5 0
R 1c 5
W 40 1
W 40 0
L S 1 0
L C 0 0
R 28 40
R 2c 10
R 30 0
